// ==== hw/readout_pkg.sv ====
/* shared widths and types of the readout path, n_fe front-end channels plus one trigger source
   the word layout follows the pyBAR tags, so the top bit alone tells trigger from data */

package readout_pkg;

    localparam int unsigned word_w    = 32;       // source and fifo word
    localparam int unsigned byte_w    = 8;        // network side stream
    localparam int unsigned n_fe      = 4;        // front-end receivers
    localparam int unsigned n_src     = n_fe + 1; // source 0 is the trigger
    localparam int unsigned chan_w    = 7;        // channel id field
    localparam int unsigned payload_w = 24;       // front-end data field

    // trigger view, flag set
    typedef struct packed {
        logic                  flag;     // always 1 here
        logic [word_w-2:0]     trig_num; // 31-bit trigger number
    } trig_word_t;

    // front-end view, flag clear
    typedef struct packed {
        logic                  flag;     // always 0 here
        logic [chan_w-1:0]     chan;     // channel index plus one
        logic [payload_w-1:0]  payload;  // raw receiver data
    } data_word_t;

    // one word, decoded through the flag bit
    typedef union packed {
        trig_word_t trig;
        data_word_t data;
    } tagged_word_u;

    // per-channel receiver status
    typedef struct packed {
        logic enabled;      // channel switched on
        logic ready;        // receiver locked
        logic decoder_err;  // 8b10b errors seen
        logic overflow_err; // receiver fifo lost data
        logic fifo_full;    // receiver fifo full now
    } rx_status_t;

endpackage

// ==== hw/source_arbiter.sv ====
/* round-robin over the selected sources, trigger hold pins the grant to source 0
   ready is combinational and one-hot, the tagged word leaves one cycle after the handshake */

`timescale 1ns/1ps

module source_arbiter (
    input  logic                                                  CLK40,
    input  logic                                                  i_arst_n,
    input  logic [readout_pkg::n_src-1:0]                         i_src_valid,
    input  logic [readout_pkg::n_src-1:0][readout_pkg::word_w-1:0] i_src_data,
    input  logic [readout_pkg::n_src-1:0]                         i_src_sel,
    input  logic                                                  i_trig_hold,
    input  logic                                                  i_out_ready,
    output logic [readout_pkg::n_src-1:0]                         o_src_ready,
    output logic                                                  o_out_valid,
    output readout_pkg::tagged_word_u                             o_out_word
);

    localparam int unsigned idx_w = $clog2(readout_pkg::n_src);

    logic [readout_pkg::n_src-1:0] elig;     // selected and holding a word
    logic [idx_w-1:0]              last_q;   // last source served
    logic [idx_w-1:0]              pick;     // winner this cycle
    logic                          any_req;  // some source eligible
    logic                          can_load; // output register free or draining
    logic                          take;     // handshake with the winner
    readout_pkg::tagged_word_u     tag;      // winner word after tagging

    assign elig     = i_src_valid & i_src_sel;
    assign can_load = !o_out_valid || i_out_ready; // refill in the drain cycle
    assign take     = any_req && can_load;

    always_comb begin : rr_pick
        int unsigned cand;
        cand    = 0;
        pick    = last_q;
        any_req = 1'b0;
        if (i_trig_hold && elig[0]) begin // hold wins over rotation
            pick    = '0;
            any_req = 1'b1;
        end else begin
            for (int k = 1; k <= readout_pkg::n_src; k++) begin
                cand = (int'(last_q) + k) % readout_pkg::n_src; // start after last served
                if (!any_req && elig[cand]) begin
                    pick    = idx_w'(cand);
                    any_req = 1'b1;
                end
            end
        end
    end

    always_comb begin
        o_src_ready = '0;
        if (take) begin
            o_src_ready[pick] = 1'b1; // at most one grant
        end
    end

    always_comb begin : tagger
        tag = '0;
        if (pick == '0) begin
            tag.trig.flag     = 1'b1;
            tag.trig.trig_num = i_src_data[0][readout_pkg::word_w-2:0];
        end else begin
            tag.data.flag    = 1'b0;
            tag.data.chan    = readout_pkg::chan_w'(pick); // index 1..n_fe is channel + 1
            tag.data.payload = i_src_data[pick][readout_pkg::payload_w-1:0];
        end
    end

    always_ff @(posedge CLK40 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_out_valid <= 1'b0;
            last_q      <= idx_w'(readout_pkg::n_src - 1); // trigger comes first
        end else begin
            if (can_load) begin
                o_out_valid <= any_req;
            end
            if (take) begin
                last_q <= pick;
            end
        end
    end

    always_ff @(posedge CLK40) begin
        if (take) begin
            o_out_word <= tag;
        end
    end

    a_onehot_ready : assert property (@(posedge CLK40) disable iff (!i_arst_n)
        $onehot0(o_src_ready));

endmodule

// ==== hw/word_fifo.sv ====
/* show-ahead word fifo, depth must be a power of two
   a written word is visible on the read side one cycle later, full is the source veto */

`timescale 1ns/1ps

module word_fifo #(
    parameter int unsigned depth = 16
) (
    input  logic                      CLK40,
    input  logic                      i_arst_n,
    input  logic                      i_wr_valid,
    input  readout_pkg::tagged_word_u i_wr_word,
    input  logic                      i_rd_ready,
    output logic                      o_wr_ready,
    output logic                      o_rd_valid,
    output readout_pkg::tagged_word_u o_rd_word,
    output logic                      o_full
);

    localparam int unsigned addr_w = $clog2(depth);

    readout_pkg::tagged_word_u mem [depth];
    logic [addr_w-1:0]         wr_ptr;
    logic [addr_w-1:0]         rd_ptr;
    logic [addr_w:0]           count;  // one extra bit to tell full from empty
    logic                      wr_en;
    logic                      rd_en;

    assign o_full     = count == (addr_w+1)'(depth);
    assign o_wr_ready = !o_full;
    assign o_rd_valid = count != '0;
    assign o_rd_word  = mem[rd_ptr]; // head shown ahead

    assign wr_en = i_wr_valid && o_wr_ready;
    assign rd_en = o_rd_valid && i_rd_ready;

    always_ff @(posedge CLK40) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_word;
        end
    end

    always_ff @(posedge CLK40 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // full stays full unless read, so nothing is written over the head
    a_no_overflow : assert property (@(posedge CLK40) disable iff (!i_arst_n)
        o_full && !rd_en |=> o_full);

    // empty stays empty unless written, so a read never underruns
    a_no_underrun : assert property (@(posedge CLK40) disable iff (!i_arst_n)
        !o_rd_valid && !wr_en |=> !o_rd_valid);

endmodule

// ==== hw/word_serializer.sv ====
/* splits each tagged word into bytes, bits 7:0 first
   a new word loads when idle or in the cycle the last byte goes, so bytes can run back to back */

`timescale 1ns/1ps

module word_serializer (
    input  logic                             CLK40,
    input  logic                             i_arst_n,
    input  logic                             i_word_valid,
    input  readout_pkg::tagged_word_u        i_word,
    input  logic                             i_byte_ready,
    output logic                             o_word_ready,
    output logic                             o_byte_valid,
    output logic [readout_pkg::byte_w-1:0]   o_byte_data
);

    localparam int unsigned n_bytes = readout_pkg::word_w / readout_pkg::byte_w;
    localparam int unsigned bidx_w  = $clog2(n_bytes);

    logic [readout_pkg::word_w-1:0] shreg;     // remaining bytes, lowest goes next
    logic [bidx_w-1:0]              byte_idx;  // byte now on the output
    logic                           busy;
    logic                           byte_xfer;
    logic                           last_xfer;
    logic                           load;

    assign byte_xfer    = busy && i_byte_ready;
    assign last_xfer    = byte_xfer && byte_idx == bidx_w'(n_bytes - 1);
    assign o_word_ready = !busy || last_xfer;
    assign load         = i_word_valid && o_word_ready;

    assign o_byte_valid = busy;
    assign o_byte_data  = shreg[readout_pkg::byte_w-1:0];

    always_ff @(posedge CLK40 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy     <= 1'b0;
            byte_idx <= '0;
        end else begin
            if (load) begin
                busy     <= 1'b1;
                byte_idx <= '0;
            end else if (last_xfer) begin
                busy     <= 1'b0; // nothing waiting
                byte_idx <= '0;
            end else if (byte_xfer) begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK40) begin
        if (load) begin
            shreg <= i_word;
        end else if (byte_xfer) begin
            shreg <= shreg >> readout_pkg::byte_w; // next byte down
        end
    end

    a_byte_stable : assert property (@(posedge CLK40) disable iff (!i_arst_n)
        o_byte_valid && !i_byte_ready |=> o_byte_valid && $stable(o_byte_data));

endmodule

// ==== hw/status_led.sv ====
/* blink levels toggle every slow_div or fast_div cycles of CLK40
   status inputs are taken as already in this clock domain */

`timescale 1ns/1ps

module status_led #(
    parameter int unsigned slow_div = 20_000_000,
    parameter int unsigned fast_div = 6_666_666
) (
    input  logic                                         CLK40,
    input  logic                                         i_arst_n,
    input  readout_pkg::rx_status_t [readout_pkg::n_fe-1:0] i_rx_status,
    input  logic                                         i_fifo_full,
    output logic [readout_pkg::n_fe:0]                   o_led
);

    localparam int unsigned slow_w = $clog2(slow_div + 1);
    localparam int unsigned fast_w = $clog2(fast_div + 1);

    logic [slow_w-1:0] slow_cnt;
    logic [fast_w-1:0] fast_cnt;
    logic              slow_blink; // idle channel rate
    logic              fast_blink; // decoder error rate

    always_ff @(posedge CLK40 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            slow_cnt   <= '0;
            slow_blink <= 1'b0;
        end else if (slow_cnt == slow_w'(slow_div - 1)) begin
            slow_cnt   <= '0;
            slow_blink <= !slow_blink;
        end else begin
            slow_cnt <= slow_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK40 or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fast_cnt   <= '0;
            fast_blink <= 1'b0;
        end else if (fast_cnt == fast_w'(fast_div - 1)) begin
            fast_cnt   <= '0;
            fast_blink <= !fast_blink;
        end else begin
            fast_cnt <= fast_cnt + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < readout_pkg::n_fe; i++) begin
            o_led[i] = i_rx_status[i].enabled && i_rx_status[i].ready
                       && ((i_rx_status[i].decoder_err ? fast_blink : slow_blink)
                           || i_rx_status[i].overflow_err
                           || i_rx_status[i].fifo_full); // errors hold it solid
        end
        o_led[readout_pkg::n_fe] = slow_blink || i_fifo_full; // heartbeat, solid when full
    end

endmodule

// ==== hw/readout_top.sv ====
/* readout data path on CLK40 only: arbiter, word fifo, byte serializer and status leds
   i_src_sel replaces the gpio selection register, bit 0 enables the trigger source */

`timescale 1ns/1ps

module readout_top #(
    parameter int unsigned fifo_depth = 1024,
    parameter int unsigned slow_div   = 20_000_000,
    parameter int unsigned fast_div   = 6_666_666
) (
    input  logic                                                  CLK40,
    input  logic                                                  i_arst_n,
    input  logic [readout_pkg::n_src-1:0]                         i_src_valid,
    input  logic [readout_pkg::n_src-1:0][readout_pkg::word_w-1:0] i_src_data,
    input  logic [readout_pkg::n_src-1:0]                         i_src_sel,
    input  logic                                                  i_trig_hold,
    output logic [readout_pkg::n_src-1:0]                         o_src_ready,
    input  logic                                                  i_byte_ready,
    output logic                                                  o_byte_valid,
    output logic [readout_pkg::byte_w-1:0]                        o_byte_data,
    output logic                                                  o_fifo_full,
    input  readout_pkg::rx_status_t [readout_pkg::n_fe-1:0]       i_rx_status,
    output logic [readout_pkg::n_fe:0]                            o_led
);

    logic                      arb_valid;
    logic                      arb_ready;  // fifo not full
    readout_pkg::tagged_word_u arb_word;
    logic                      fifo_valid;
    logic                      ser_ready;
    readout_pkg::tagged_word_u fifo_word;

    source_arbiter arb_i (
        .CLK40       (CLK40),
        .i_arst_n    (i_arst_n),
        .i_src_valid (i_src_valid),
        .i_src_data  (i_src_data),
        .i_src_sel   (i_src_sel),
        .i_trig_hold (i_trig_hold),
        .i_out_ready (arb_ready),
        .o_src_ready (o_src_ready),
        .o_out_valid (arb_valid),
        .o_out_word  (arb_word)
    );

    word_fifo #(.depth(fifo_depth)) fifo_i (
        .CLK40      (CLK40),
        .i_arst_n   (i_arst_n),
        .i_wr_valid (arb_valid),
        .i_wr_word  (arb_word),
        .i_rd_ready (ser_ready),
        .o_wr_ready (arb_ready),
        .o_rd_valid (fifo_valid),
        .o_rd_word  (fifo_word),
        .o_full     (o_fifo_full) // also the veto for the sources
    );

    word_serializer ser_i (
        .CLK40        (CLK40),
        .i_arst_n     (i_arst_n),
        .i_word_valid (fifo_valid),
        .i_word       (fifo_word),
        .i_byte_ready (i_byte_ready),
        .o_word_ready (ser_ready),
        .o_byte_valid (o_byte_valid),
        .o_byte_data  (o_byte_data)
    );

    status_led #(.slow_div(slow_div), .fast_div(fast_div)) led_i (
        .CLK40       (CLK40),
        .i_arst_n    (i_arst_n),
        .i_rx_status (i_rx_status),
        .i_fifo_full (o_fifo_full),
        .o_led       (o_led)
    );

endmodule

// ==== bench/tb_model.svh ====
/* reference rules of the readout path, included inside the testbench module body
   check_value counts into err_val of the including module */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// source 0 keeps 31 bits under the flag, source k gets channel id k and 24 bits
function automatic logic [31:0] tag_ref(input int src, input logic [31:0] raw);
    return (src == 0) ? {1'b1, raw[30:0]} : {1'b0, 7'(src), raw[23:0]};
endfunction

// square wave after cyc cycles, level flips every div cycles
function automatic logic blink_ref(input int unsigned cyc, input int unsigned div);
    return ((cyc / div) % 2) == 1;
endfunction

function automatic logic led_ref(input readout_pkg::rx_status_t st, input logic slow,
                                 input logic fast);
    if (!(st.enabled && st.ready))
        return 1'b0;                  // dark unless enabled and locked
    if (st.overflow_err || st.fifo_full)
        return 1'b1;                  // solid on errors
    return st.decoder_err ? fast : slow;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
        err_val++;
        $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

`endif

// ==== bench/tb_readout.sv ====
/* random sources and byte back-pressure from one fixed seed, source 2 left unselected
   16-word fifo and short blink dividers so fill and LED timing show up quickly */

`timescale 1ns/1ps

module tb_readout;

    localparam int unsigned n_src     = readout_pkg::n_src;
    localparam int unsigned max_words = 40; // per source over all phases
    localparam int unsigned wd_cycles = n_src * max_words * 4 * 8 + 2000;

    logic                                       CLK40 = 1'b0;
    logic                                       i_arst_n;
    logic [n_src-1:0]                           i_src_valid = '0;
    logic [n_src-1:0][31:0]                     i_src_data = '0;
    logic [n_src-1:0]                           i_src_sel;
    logic                                       i_trig_hold;
    logic [n_src-1:0]                           o_src_ready;
    logic                                       i_byte_ready = 1'b0;
    logic                                       o_byte_valid;
    logic [7:0]                                 o_byte_data;
    logic                                       o_fifo_full;
    readout_pkg::rx_status_t [readout_pkg::n_fe-1:0] i_rx_status;
    logic [readout_pkg::n_fe:0]                 o_led;

    integer      seed = 49792;
    int unsigned err_val = 0;                      // wrong values
    int unsigned err_proto = 0;                    // handshake and ordering failures
    int unsigned src_limit;                        // words per source allowed so far
    logic        br_stall;                         // hold i_byte_ready low
    int unsigned sent_cnt [n_src] = '{default: 0};
    int unsigned rcv_cnt = 0;
    int unsigned led_cyc = 0;                      // cycles since reset release
    logic [31:0] exp_q [n_src][$];                 // owed tagged words per source
    logic [31:0] asm_word = '0;                    // word built from bytes
    int unsigned asm_idx = 0;

    `include "tb_model.svh"

    readout_top #(.fifo_depth(16), .slow_div(8), .fast_div(3)) dut_i (.*);

    always #10 CLK40 = ~CLK40; // 20 ns period

    always @(posedge CLK40) begin : drive_sources
        logic        xfer;
        int unsigned n;
        for (int s = 0; s < n_src; s++) begin
            xfer = i_src_valid[s] && o_src_ready[s];
            n    = sent_cnt[s] + 32'(xfer);
            if (xfer) begin
                exp_q[s].push_back(tag_ref(s, i_src_data[s])); // now owed downstream
                sent_cnt[s] <= n;
            end
            if (xfer || !i_src_valid[s]) begin // word held until taken
                i_src_valid[s] <= n < src_limit && ($random(seed) & 3) != 0;
                i_src_data[s]  <= $random(seed);
            end
        end
    end

    always @(posedge CLK40) begin : pace
        i_byte_ready <= !br_stall && ($random(seed) & 3) != 0; // about three in four
        if (i_arst_n)
            led_cyc <= led_cyc + 1; // blink time base
    end

    always @(posedge CLK40) begin : collect_bytes
        int src;
        if (i_arst_n && o_byte_valid && i_byte_ready) begin
            asm_word[8*asm_idx +: 8] = o_byte_data; // bits 7:0 first
            asm_idx = (asm_idx + 1) % 4;
            if (asm_idx == 0) begin
                rcv_cnt++;
                src = asm_word[31] ? 0 : int'(asm_word[30:24]); // queue by flag and channel
                if (src >= int'(n_src) || (!asm_word[31] && src == 0)
                    || exp_q[src].size() == 0) begin
                    err_proto++;
                    $display("word %h at %0t belongs to no source or came twice", asm_word, $time);
                end else begin
                    check_value($sformatf("word of source %0d", src), asm_word,
                                exp_q[src].pop_front());
                end
            end
        end
    end

    always @(negedge CLK40) begin : watch_outputs
        logic slow;
        logic fast;
        slow = blink_ref(led_cyc, 8);
        fast = blink_ref(led_cyc, 3);
        if (i_arst_n) begin
            if (!i_src_sel[2])
                check_value("o_src_ready[2]", 32'(o_src_ready[2]), 32'(0)); // unselected
            if (i_trig_hold && i_src_valid[0] && i_src_sel[0])
                check_value("o_src_ready[4:1]", 32'(o_src_ready[n_src-1:1]), 32'(0));
            for (int i = 0; i < readout_pkg::n_fe; i++)
                check_value($sformatf("o_led[%0d]", i), 32'(o_led[i]),
                            32'(led_ref(i_rx_status[i], slow, fast)));
            check_value("o_led[4]", 32'(o_led[4]), 32'(slow || o_fifo_full));
        end
    end

    task automatic wait_sources();
        int unsigned left;
        do begin
            @(posedge CLK40);
            left = 0;
            foreach (sent_cnt[s])
                left += (i_src_sel[s] && sent_cnt[s] < src_limit) ? 1 : 0;
        end while (left != 0);
    endtask

    initial begin : run_tests
        i_arst_n    <= 1'b0;
        i_src_sel   <= 5'b11011; // source 2 left out
        i_trig_hold <= 1'b0;
        i_rx_status <= '0;
        src_limit   <= 0;
        br_stall    <= 1'b0;
        repeat (9) @(posedge CLK40);
        @(negedge CLK40);
        check_value("o_src_ready", 32'(o_src_ready), 32'(0)); // all low in reset
        check_value("o_byte_valid", 32'(o_byte_valid), 32'(0));
        check_value("o_fifo_full", 32'(o_fifo_full), 32'(0));
        check_value("o_led", 32'(o_led), 32'(0));
        @(posedge CLK40);
        i_arst_n    <= 1'b1;
        // ch3 decoder_err, ch2 plain, ch1 overflow_err, ch0 ready but disabled
        i_rx_status <= {5'b11100, 5'b11000, 5'b11010, 5'b01000};
        src_limit   <= 20;
        wait_sources();
        i_trig_hold <= 1'b1;
        src_limit   <= 30;
        wait_sources();
        i_trig_hold <= 1'b0;
        br_stall    <= 1'b1;
        src_limit   <= max_words;
        while (!o_fifo_full) @(posedge CLK40);
        repeat (2) @(posedge CLK40); // arbiter register fills behind the fifo
        repeat (8) begin
            @(negedge CLK40);
            check_value("o_src_ready", 32'(o_src_ready), 32'(0)); // byte side stalled
            check_value("o_fifo_full", 32'(o_fifo_full), 32'(1));
        end
        @(posedge CLK40);
        br_stall <= 1'b0;
        wait_sources();
        foreach (exp_q[s])
            while (exp_q[s].size() != 0) @(posedge CLK40);
        repeat (50) @(posedge CLK40); // room for stray words
        check_value("received word count", rcv_cnt, sent_cnt.sum());
        $display("value errors %0d, protocol errors %0d, words %0d", err_val, err_proto, rcv_cnt);
        if (err_val == 0 && err_proto == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (wd_cycles) @(posedge CLK40);
        $display("timeout, the run did not finish within %0d cycles", wd_cycles);
        $display("value errors %0d, protocol errors %0d, words %0d", err_val, err_proto, rcv_cnt);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== readout_top.f ====
+incdir+bench
hw/readout_pkg.sv
hw/source_arbiter.sv
hw/word_fifo.sv
hw/word_serializer.sv
hw/status_led.sv
hw/readout_top.sv
bench/tb_readout.sv

// ==== Makefile ====
SIM    := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_readout
FLIST  := readout_top.f
OBJDIR := obj_dir
LOG    := sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := bench/tb_model.svh
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
